// ==== rename_core.f ====
verilog/arch_pkg.sv
verilog/rename_pkg.sv
verilog/reg_status.sv
verilog/reorder_buffer.sv
verilog/issue_unit.sv
verilog/retire_unit.sv
verilog/rename_core.sv
bench/rename_core_sva.sv
bench/rename_core_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = rename_core_tb
FILELIST  = rename_core.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir

// ==== bench/rename_core_tb.sv ====
// directed testbench for the rename core, checks operands and retirements against a small model
`timescale 1ns/1ns

module rename_core_tb;
    import arch_pkg::*;
    import rename_pkg::*;

    localparam int tag_bits = default_rob_tag_bits;
    localparam int depth = 1 << tag_bits;
    // issues, writebacks and retirements per test, in test order
    localparam int op_count = 12 + 12 + 30 + 9 + 27 + 13;
    localparam int cycle_limit = 40 * op_count;

    typedef struct packed {
        logic [tag_bits-1:0]    tag;
        logic [reg_id_bits-1:0] rd;
        logic                   done;
        logic [xlen-1:0]        value;
    } entry_t;

    typedef struct packed {
        logic                busy;
        logic [tag_bits-1:0] tag;
        logic [xlen-1:0]     value;
    } operand_t;

    logic clk_in, rst_in, flush, inst_req, inst_ack, wb_valid, retire_req, retire_ack;
    logic src1_busy, src2_busy;
    logic [reg_id_bits-1:0] inst_rd, inst_rs1, inst_rs2, retire_rd;
    logic [xlen-1:0] src1_value, src2_value, wb_value, retire_value;
    logic [tag_bits-1:0] src1_tag, src2_tag, dest_tag, wb_tag, retire_tag;

    // reference model: committed registers and in-flight entries oldest first
    logic [xlen-1:0] arch_regs [reg_count];
    entry_t pending [$];
    logic [tag_bits-1:0] next_tag;
    logic [31:0] lfsr_state;
    int check_count;
    int error_count;
    int cycle_count = 0;
    string test_name;

    rename_core #(.rob_tag_bits(tag_bits)) dut_i (.*);

    bind rename_core rename_core_sva sva_i (
        .clk_in(clk_in), .rst_in(rst_in), .inst_req(inst_req), .inst_ack(inst_ack),
        .retire_req(retire_req), .retire_ack(retire_ack),
        .read_id1(read_id1), .read_id2(read_id2), .busy1(busy1), .busy2(busy2)
    );

    always #5 clk_in = ~clk_in;

    always @(posedge clk_in) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout, a handshake did not complete within %0d cycles", cycle_limit);
            $display("** FAIL **");
            $finish;
        end
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic int random_reg();
        return int'(random_bits(reg_id_bits));
    endfunction

    task automatic check(input string label, input logic [31:0] expected, input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERR %s %s expected %h actual %h", test_name, label, expected, actual);
        end
    endtask

    task automatic report_failure(input string what);
        error_count++;
        $display("%s: %s", test_name, what);
    endtask

    // youngest producer wins, a finished one reads as its value
    function automatic operand_t expected_operand(input logic [reg_id_bits-1:0] r);
        operand_t op;
        op.busy = 1'b0;
        op.tag = tag_bits'(null_tag);
        op.value = arch_regs[r];
        foreach (pending[i]) begin
            if (r != zero_reg && pending[i].rd == r) begin
                op.busy = !pending[i].done;
                op.tag = pending[i].done ? tag_bits'(null_tag) : pending[i].tag;
                op.value = pending[i].done ? pending[i].value : arch_regs[r];
            end
        end
        return op;
    endfunction

    task automatic do_issue(input int rd, input int rs1, input int rs2);
        operand_t op1;
        operand_t op2;
        entry_t e;
        op1 = expected_operand(reg_id_bits'(rs1));
        op2 = expected_operand(reg_id_bits'(rs2));
        @(negedge clk_in);
        inst_req = 1'b1;
        inst_rd = reg_id_bits'(rd);
        inst_rs1 = reg_id_bits'(rs1);
        inst_rs2 = reg_id_bits'(rs2);
        @(negedge clk_in);
        while (!inst_ack) begin
            @(negedge clk_in);
        end
        check("src1 value", op1.value, src1_value);
        check("src1 busy", 32'(op1.busy), 32'(src1_busy));
        check("src1 tag", 32'(op1.tag), 32'(src1_tag));
        check("src2 value", op2.value, src2_value);
        check("src2 busy", 32'(op2.busy), 32'(src2_busy));
        check("src2 tag", 32'(op2.tag), 32'(src2_tag));
        check("dest tag", 32'(next_tag), 32'(dest_tag));
        e.tag = next_tag;
        e.rd = reg_id_bits'(rd);
        e.done = 1'b0;
        e.value = '0;
        pending.push_back(e);
        next_tag = next_tag + tag_bits'(1);
        inst_req = 1'b0;
        while (inst_ack) begin
            @(negedge clk_in);
        end
    endtask

    task automatic do_writeback(input logic [tag_bits-1:0] tag, input logic [xlen-1:0] value);
        entry_t e;
        @(negedge clk_in);
        wb_valid = 1'b1;
        wb_tag = tag;
        wb_value = value;
        @(negedge clk_in);
        wb_valid = 1'b0;
        foreach (pending[i]) begin
            if (pending[i].tag == tag && !pending[i].done) begin
                e = pending[i];
                e.done = 1'b1;
                e.value = value;
                pending[i] = e;
            end
        end
    endtask

    task automatic expect_retire();
        entry_t e;
        @(negedge clk_in);
        while (!retire_req) begin
            @(negedge clk_in);
        end
        if (pending.size() == 0) begin
            report_failure("retirement reported with no entry outstanding");
        end else begin
            e = pending.pop_front();
            if (!e.done) begin
                report_failure("entry retired before its result was written back");
            end
            check("retire rd", 32'(e.rd), 32'(retire_rd));
            check("retire value", e.value, retire_value);
            check("retire tag", 32'(e.tag), 32'(retire_tag));
            if (e.rd != zero_reg) begin
                arch_regs[e.rd] = e.value;
            end
        end
        retire_ack = 1'b1;
        @(negedge clk_in);
        while (retire_req) begin
            @(negedge clk_in);
        end
        retire_ack = 1'b0;
    endtask

    // every open entry written back, in shuffled order
    task automatic writeback_shuffled();
        logic [tag_bits-1:0] order [$];
        logic [tag_bits-1:0] swap;
        int j;
        foreach (pending[i]) begin
            if (!pending[i].done) begin
                order.push_back(pending[i].tag);
            end
        end
        for (int i = order.size() - 1; i > 0; i--) begin
            j = int'(random_bits(tag_bits) % 32'(i + 1));
            swap = order[i];
            order[i] = order[j];
            order[j] = swap;
        end
        foreach (order[i]) begin
            do_writeback(order[i], random_bits(xlen));
        end
    endtask

    task automatic drain();
        writeback_shuffled();
        while (pending.size() > 0) begin
            expect_retire();
        end
    endtask

    task automatic test_reset_reads();
        test_name = "reset reads";
        for (int k = 0; k < 4; k++) begin
            do_issue(0, random_reg(), random_reg());
        end
        drain();
    endtask

    task automatic test_dependency();
        logic [tag_bits-1:0] producer;
        test_name = "dependency";
        // x1 stays at the head unwritten so x5 has to come from the bypass
        do_issue(1, 0, 0);
        producer = next_tag;
        do_issue(5, 1, 0);
        do_issue(6, 5, 5);
        do_writeback(producer, random_bits(xlen));
        do_issue(7, 5, 6);
        drain();
    endtask

    task automatic test_in_order();
        test_name = "in order";
        for (int k = 0; k < 6; k++) begin
            do_issue(1 + int'(random_bits(3)), random_reg(), random_reg());
        end
        drain();
        for (int k = 1; k <= 8; k += 2) begin
            do_issue(0, k, k + 1);
        end
        drain();
    endtask

    task automatic test_x0_dest();
        test_name = "x0 dest";
        do_issue(0, 0, 0);
        // x0 read again while an x0 result is in flight
        do_issue(0, 0, 0);
        do_writeback(pending[0].tag, random_bits(xlen) | 32'h1);
        expect_retire();
        do_issue(0, 0, 0);
        drain();
    endtask

    task automatic test_back_pressure();
        test_name = "back pressure";
        for (int k = 0; k < depth; k++) begin
            do_issue(10 + k, random_reg(), random_reg());
        end
        fork
            do_issue(20, 0, 5);
            begin
                // buffer full, the extra request must stay unanswered
                repeat (6) begin
                    @(negedge clk_in);
                    check("stalled ack", 32'(1'b0), 32'(inst_ack));
                end
                writeback_shuffled();
                repeat (depth) expect_retire();
            end
        join
        drain();
    endtask

    task automatic test_flush();
        test_name = "flush";
        do_issue(21, random_reg(), random_reg());
        do_issue(22, 21, 0);
        do_issue(23, 22, 21);
        do_writeback(pending[1].tag, random_bits(xlen));
        do_writeback(pending[2].tag, random_bits(xlen));
        // head finishes last so its report is still open at the flush
        do_writeback(pending[0].tag, random_bits(xlen));
        @(negedge clk_in);
        flush = 1'b1;
        @(negedge clk_in);
        flush = 1'b0;
        // only the already reported head survives
        while (pending.size() > 1) begin
            pending.delete(pending.size() - 1);
        end
        next_tag = '0;
        expect_retire();
        repeat (8) begin
            @(negedge clk_in);
            if (retire_req) begin
                report_failure("a flushed entry was reported for retirement");
            end
        end
        do_issue(0, 21, 22);
        do_issue(0, 23, 0);
        drain();
    endtask

    initial begin
        clk_in = 1'b0;
        rst_in = 1'b1;
        flush = 1'b0;
        inst_req = 1'b0;
        inst_rd = '0;
        inst_rs1 = '0;
        inst_rs2 = '0;
        wb_valid = 1'b0;
        wb_tag = '0;
        wb_value = '0;
        retire_ack = 1'b0;
        lfsr_state = 32'h3b72;
        next_tag = '0;
        check_count = 0;
        error_count = 0;
        test_name = "reset";
        foreach (arch_regs[i]) begin
            arch_regs[i] = '0;
        end
        repeat (4) @(posedge clk_in);
        @(negedge clk_in);
        rst_in = 1'b0;
        test_reset_reads();
        test_dependency();
        test_in_order();
        test_x0_dest();
        test_back_pressure();
        test_flush();
        $display("checks %0d errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== bench/rename_core_sva.sv ====
// concurrent checks on the rename core handshakes and x0 reads, bound into the core by the testbench
`timescale 1ns/1ns

module rename_core_sva (
    input logic                            clk_in,
    input logic                            rst_in,
    input logic                            inst_req,
    input logic                            inst_ack,
    input logic                            retire_req,
    input logic                            retire_ack,
    input logic [arch_pkg::reg_id_bits-1:0] read_id1,
    input logic [arch_pkg::reg_id_bits-1:0] read_id2,
    input logic                            busy1,
    input logic                            busy2
);
    import arch_pkg::*;

    // ack only answers a request that was up in the cycle before
    ack_follows_req: assert property (@(posedge clk_in) disable iff (rst_in)
        $rose(inst_ack) |-> $past(inst_req))
        else $error("inst_ack rose without inst_req");

    // request held until the outside acknowledges it
    req_held_until_ack: assert property (@(posedge clk_in) disable iff (rst_in)
        retire_req && !retire_ack |=> retire_req)
        else $error("retire_req dropped before retire_ack");

    // x0 is never renamed
    x0_never_busy: assert property (@(posedge clk_in) disable iff (rst_in)
        (read_id1 == zero_reg |-> !busy1) and (read_id2 == zero_reg |-> !busy2))
        else $error("read of x0 shows busy");

endmodule

// ==== verilog/rename_core.sv ====
// top level of the rename and retire core, connects issue, register status, buffer and retire
`timescale 1ns/1ns

module rename_core #(
    parameter int rob_tag_bits = rename_pkg::default_rob_tag_bits
) (
    input  logic                            clk_in,
    input  logic                            rst_in,
    input  logic                            flush,
    // instruction handshake
    input  logic                            inst_req,
    input  logic [arch_pkg::reg_id_bits-1:0] inst_rd,
    input  logic [arch_pkg::reg_id_bits-1:0] inst_rs1,
    input  logic [arch_pkg::reg_id_bits-1:0] inst_rs2,
    output logic                            inst_ack,
    output logic [arch_pkg::xlen-1:0]        src1_value,
    output logic                            src1_busy,
    output logic [rob_tag_bits-1:0]          src1_tag,
    output logic [arch_pkg::xlen-1:0]        src2_value,
    output logic                            src2_busy,
    output logic [rob_tag_bits-1:0]          src2_tag,
    output logic [rob_tag_bits-1:0]          dest_tag,
    // writeback strobe
    input  logic                            wb_valid,
    input  logic [rob_tag_bits-1:0]          wb_tag,
    input  logic [arch_pkg::xlen-1:0]        wb_value,
    // retirement handshake
    output logic                            retire_req,
    output logic [arch_pkg::reg_id_bits-1:0] retire_rd,
    output logic [arch_pkg::xlen-1:0]        retire_value,
    output logic [rob_tag_bits-1:0]          retire_tag,
    input  logic                            retire_ack
);
    import arch_pkg::*;

    logic [reg_id_bits-1:0]  read_id1;
    logic [reg_id_bits-1:0]  read_id2;
    logic [xlen-1:0]         value1;
    logic                    busy1;
    logic [rob_tag_bits-1:0] tag1;
    logic [xlen-1:0]         value2;
    logic                    busy2;
    logic [rob_tag_bits-1:0] tag2;
    logic                    alloc;
    logic [reg_id_bits-1:0]  alloc_rd;
    logic [rob_tag_bits-1:0] alloc_tag;
    logic                    full;
    logic [rob_tag_bits-1:0] lookup_tag1;
    logic [rob_tag_bits-1:0] lookup_tag2;
    logic                    lookup_done1;
    logic [xlen-1:0]         lookup_value1;
    logic                    lookup_done2;
    logic [xlen-1:0]         lookup_value2;
    logic                    commit;
    logic                    head_valid;
    logic                    head_done;
    logic [reg_id_bits-1:0]  head_rd;
    logic [xlen-1:0]         head_value;
    logic [rob_tag_bits-1:0] head_tag;

    issue_unit #(.rob_tag_bits(rob_tag_bits)) issue_i (
        .clk_in(clk_in), .rst_in(rst_in), .flush(flush),
        .inst_req(inst_req), .inst_rd(inst_rd), .inst_rs1(inst_rs1), .inst_rs2(inst_rs2),
        .inst_ack(inst_ack),
        .src1_value(src1_value), .src1_busy(src1_busy), .src1_tag(src1_tag),
        .src2_value(src2_value), .src2_busy(src2_busy), .src2_tag(src2_tag),
        .dest_tag(dest_tag),
        .read_id1(read_id1), .read_id2(read_id2), .alloc(alloc), .alloc_rd(alloc_rd),
        .value1(value1), .busy1(busy1), .tag1(tag1),
        .value2(value2), .busy2(busy2), .tag2(tag2),
        .alloc_tag(alloc_tag), .full(full)
    );

    // commit port fed straight from the buffer head
    reg_status #(.rob_tag_bits(rob_tag_bits)) reg_status_i (
        .clk_in(clk_in), .rst_in(rst_in), .flush(flush),
        .read_id1(read_id1), .read_id2(read_id2),
        .value1(value1), .busy1(busy1), .tag1(tag1),
        .value2(value2), .busy2(busy2), .tag2(tag2),
        .lookup_tag1(lookup_tag1), .lookup_tag2(lookup_tag2),
        .lookup_done1(lookup_done1), .lookup_value1(lookup_value1),
        .lookup_done2(lookup_done2), .lookup_value2(lookup_value2),
        .alloc(alloc), .alloc_rd(alloc_rd), .alloc_tag(alloc_tag),
        .commit(commit), .commit_rd(head_rd), .commit_value(head_value), .commit_tag(head_tag)
    );

    reorder_buffer #(.rob_tag_bits(rob_tag_bits)) rob_i (
        .clk_in(clk_in), .rst_in(rst_in), .flush(flush),
        .alloc(alloc), .alloc_rd(alloc_rd), .alloc_tag(alloc_tag), .full(full),
        .wb_valid(wb_valid), .wb_tag(wb_tag), .wb_value(wb_value),
        .lookup_tag1(lookup_tag1), .lookup_tag2(lookup_tag2),
        .lookup_done1(lookup_done1), .lookup_value1(lookup_value1),
        .lookup_done2(lookup_done2), .lookup_value2(lookup_value2),
        .commit(commit), .head_valid(head_valid), .head_done(head_done),
        .head_rd(head_rd), .head_value(head_value), .head_tag(head_tag)
    );

    retire_unit #(.rob_tag_bits(rob_tag_bits)) retire_i (
        .clk_in(clk_in), .rst_in(rst_in),
        .head_valid(head_valid), .head_done(head_done), .head_rd(head_rd),
        .head_value(head_value), .head_tag(head_tag), .commit(commit),
        .retire_req(retire_req), .retire_rd(retire_rd), .retire_value(retire_value),
        .retire_tag(retire_tag), .retire_ack(retire_ack)
    );

endmodule

// ==== verilog/retire_unit.sv ====
// in-order retirement of the buffer head, reported outward over a four-phase req/ack handshake
`timescale 1ns/1ns

module retire_unit #(
    parameter int rob_tag_bits
) (
    input  logic                            clk_in,
    input  logic                            rst_in,
    // buffer head
    input  logic                            head_valid,
    input  logic                            head_done,
    input  logic [arch_pkg::reg_id_bits-1:0] head_rd,
    input  logic [arch_pkg::xlen-1:0]        head_value,
    input  logic [rob_tag_bits-1:0]          head_tag,
    output logic                            commit,
    // retirement report
    output logic                            retire_req,
    output logic [arch_pkg::reg_id_bits-1:0] retire_rd,
    output logic [arch_pkg::xlen-1:0]        retire_value,
    output logic [rob_tag_bits-1:0]          retire_tag,
    input  logic                            retire_ack
);
    import arch_pkg::*;

    // one commit per handshake, only once the previous one fully closed
    assign commit = head_valid && head_done && !retire_req && !retire_ack;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            retire_req <= 1'b0;
        end else if (commit) begin
            retire_req <= 1'b1;
        end else if (retire_ack) begin
            retire_req <= 1'b0;
        end
    end

    // report fields held for the whole handshake
    always_ff @(posedge clk_in) begin
        if (commit) begin
            retire_rd    <= head_rd;
            retire_value <= head_value;
            retire_tag   <= head_tag;
        end
    end

endmodule

// ==== verilog/issue_unit.sv ====
// instruction intake over a four-phase req/ack handshake, renames operands and allocates entries
`timescale 1ns/1ns

module issue_unit #(
    parameter int rob_tag_bits = rename_pkg::default_rob_tag_bits
) (
    input  logic                            clk_in,
    input  logic                            rst_in,
    input  logic                            flush,
    // instruction handshake
    input  logic                            inst_req,
    input  logic [arch_pkg::reg_id_bits-1:0] inst_rd,
    input  logic [arch_pkg::reg_id_bits-1:0] inst_rs1,
    input  logic [arch_pkg::reg_id_bits-1:0] inst_rs2,
    output logic                            inst_ack,
    output logic [arch_pkg::xlen-1:0]        src1_value,
    output logic                            src1_busy,
    output logic [rob_tag_bits-1:0]          src1_tag,
    output logic [arch_pkg::xlen-1:0]        src2_value,
    output logic                            src2_busy,
    output logic [rob_tag_bits-1:0]          src2_tag,
    output logic [rob_tag_bits-1:0]          dest_tag,
    // register status side
    output logic [arch_pkg::reg_id_bits-1:0] read_id1,
    output logic [arch_pkg::reg_id_bits-1:0] read_id2,
    output logic                            alloc,
    output logic [arch_pkg::reg_id_bits-1:0] alloc_rd,
    input  logic [arch_pkg::xlen-1:0]        value1,
    input  logic                            busy1,
    input  logic [rob_tag_bits-1:0]          tag1,
    input  logic [arch_pkg::xlen-1:0]        value2,
    input  logic                            busy2,
    input  logic [rob_tag_bits-1:0]          tag2,
    // reorder buffer side
    input  logic [rob_tag_bits-1:0]          alloc_tag,
    input  logic                            full
);
    import arch_pkg::*;

    logic accept;

    // fields are stable while req is high, so read straight from them
    assign read_id1 = inst_rs1;
    assign read_id2 = inst_rs2;
    assign alloc_rd = inst_rd;

    // new request, room in the buffer, no flush this cycle
    assign accept = inst_req && !inst_ack && !full && !flush;
    assign alloc  = accept;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            inst_ack <= 1'b0;
        end else if (accept) begin
            inst_ack <= 1'b1;
        end else if (!inst_req) begin
            inst_ack <= 1'b0;
        end
    end

    // operands as seen before the accepting edge
    always_ff @(posedge clk_in) begin
        if (accept) begin
            src1_value <= value1;
            src1_busy  <= busy1;
            src1_tag   <= tag1;
            src2_value <= value2;
            src2_busy  <= busy2;
            src2_tag   <= tag2;
            dest_tag   <= alloc_tag;
        end
    end

endmodule

// ==== verilog/reorder_buffer.sv ====
// circular reorder buffer holding in-flight results until they retire in program order
`timescale 1ns/1ns

module reorder_buffer #(
    parameter int rob_tag_bits = rename_pkg::default_rob_tag_bits
) (
    input  logic                            clk_in,
    input  logic                            rst_in,
    input  logic                            flush,
    // allocation at the tail
    input  logic                            alloc,
    input  logic [arch_pkg::reg_id_bits-1:0] alloc_rd,
    output logic [rob_tag_bits-1:0]          alloc_tag,
    output logic                            full,
    // result writeback from the execution units
    input  logic                            wb_valid,
    input  logic [rob_tag_bits-1:0]          wb_tag,
    input  logic [arch_pkg::xlen-1:0]        wb_value,
    // operand bypass lookups
    input  logic [rob_tag_bits-1:0]          lookup_tag1,
    input  logic [rob_tag_bits-1:0]          lookup_tag2,
    output logic                            lookup_done1,
    output logic [arch_pkg::xlen-1:0]        lookup_value1,
    output logic                            lookup_done2,
    output logic [arch_pkg::xlen-1:0]        lookup_value2,
    // head of the buffer towards retirement
    input  logic                            commit,
    output logic                            head_valid,
    output logic                            head_done,
    output logic [arch_pkg::reg_id_bits-1:0] head_rd,
    output logic [arch_pkg::xlen-1:0]        head_value,
    output logic [rob_tag_bits-1:0]          head_tag
);
    import arch_pkg::*;

    localparam int depth = 1 << rob_tag_bits;

    logic [rob_tag_bits-1:0] head;
    logic [rob_tag_bits-1:0] tail;
    // one bit wider than a pointer so a full buffer is distinct from empty
    logic [rob_tag_bits:0]   count;
    logic [depth-1:0]        done_r;
    logic [reg_id_bits-1:0]  rd_r [depth];
    logic [xlen-1:0]         value_r [depth];

    assign alloc_tag = tail;
    assign full      = (count == (rob_tag_bits + 1)'(depth));

    assign lookup_done1  = done_r[lookup_tag1];
    assign lookup_value1 = value_r[lookup_tag1];
    assign lookup_done2  = done_r[lookup_tag2];
    assign lookup_value2 = value_r[lookup_tag2];

    assign head_valid = (count != '0);
    assign head_done  = done_r[head];
    assign head_rd    = rd_r[head];
    assign head_value = value_r[head];
    assign head_tag   = head;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            head   <= '0;
            tail   <= '0;
            count  <= '0;
            done_r <= '0;
        end else if (flush) begin
            // drop every speculative entry, done bits are rewritten on alloc
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (alloc) begin
                tail         <= tail + 1'b1;
                done_r[tail] <= 1'b0;
            end
            // visible to lookups from the next cycle on
            if (wb_valid) begin
                done_r[wb_tag] <= 1'b1;
            end
            if (commit) begin
                head <= head + 1'b1;
            end
            case ({alloc, commit})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // entry payload
    always_ff @(posedge clk_in) begin
        if (alloc) begin
            rd_r[tail] <= alloc_rd;
        end
        if (wb_valid) begin
            value_r[wb_tag] <= wb_value;
        end
    end

endmodule

// ==== verilog/reg_status.sv ====
// architectural register file with busy bits and producer tags, read by issue and written by retire
`timescale 1ns/1ns

module reg_status #(
    parameter int rob_tag_bits = rename_pkg::default_rob_tag_bits
) (
    input  logic                            clk_in,
    input  logic                            rst_in,
    input  logic                            flush,
    // operand read ports
    input  logic [arch_pkg::reg_id_bits-1:0] read_id1,
    input  logic [arch_pkg::reg_id_bits-1:0] read_id2,
    output logic [arch_pkg::xlen-1:0]        value1,
    output logic                            busy1,
    output logic [rob_tag_bits-1:0]          tag1,
    output logic [arch_pkg::xlen-1:0]        value2,
    output logic                            busy2,
    output logic [rob_tag_bits-1:0]          tag2,
    // bypass lookups into the reorder buffer
    output logic [rob_tag_bits-1:0]          lookup_tag1,
    output logic [rob_tag_bits-1:0]          lookup_tag2,
    input  logic                            lookup_done1,
    input  logic [arch_pkg::xlen-1:0]        lookup_value1,
    input  logic                            lookup_done2,
    input  logic [arch_pkg::xlen-1:0]        lookup_value2,
    // rename of a destination
    input  logic                            alloc,
    input  logic [arch_pkg::reg_id_bits-1:0] alloc_rd,
    input  logic [rob_tag_bits-1:0]          alloc_tag,
    // retirement of the buffer head
    input  logic                            commit,
    input  logic [arch_pkg::reg_id_bits-1:0] commit_rd,
    input  logic [arch_pkg::xlen-1:0]        commit_value,
    input  logic [rob_tag_bits-1:0]          commit_tag
);
    import arch_pkg::*;
    import rename_pkg::*;

    logic [xlen-1:0]         regs [reg_count];
    logic [reg_count-1:0]    busy;
    logic [rob_tag_bits-1:0] tags [reg_count];
    logic                    hit1;
    logic                    hit2;

    // producer tag goes to the buffer regardless, busy decides if it matters
    assign lookup_tag1 = tags[read_id1];
    assign lookup_tag2 = tags[read_id2];

    // busy register whose producer already finished
    assign hit1 = busy[read_id1] && lookup_done1;
    assign hit2 = busy[read_id2] && lookup_done2;

    assign busy1  = busy[read_id1] && !lookup_done1;
    assign value1 = hit1 ? lookup_value1 : regs[read_id1];
    assign tag1   = busy1 ? tags[read_id1] : rob_tag_bits'(null_tag);

    assign busy2  = busy[read_id2] && !lookup_done2;
    assign value2 = hit2 ? lookup_value2 : regs[read_id2];
    assign tag2   = busy2 ? tags[read_id2] : rob_tag_bits'(null_tag);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            busy <= '0;
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // a reported retirement still lands even across a flush
            if (commit && commit_rd != zero_reg) begin
                regs[commit_rd] <= commit_value;
            end
            if (flush) begin
                busy <= '0;
            end else begin
                // only the newest producer clears the busy bit
                if (commit && tags[commit_rd] == commit_tag) begin
                    busy[commit_rd] <= 1'b0;
                end
                // later assignment, so a same-cycle rename wins over the clear
                if (alloc && alloc_rd != zero_reg) begin
                    busy[alloc_rd] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (alloc && !flush && alloc_rd != zero_reg) begin
            tags[alloc_rd] <= alloc_tag;
        end
    end

endmodule

// ==== verilog/rename_pkg.sv ====
// reorder buffer sizing and tag encoding shared by the rename and retire blocks
package rename_pkg;

    // 3 tag bits give an 8-entry reorder buffer
    localparam int default_rob_tag_bits = 3;

    // tag shown on an operand that has no pending producer
    localparam int unsigned null_tag = 0;

endpackage

// ==== verilog/arch_pkg.sv ====
// RV32 integer register file sizes, imported by every RTL block of the rename core
package arch_pkg;

    // data word width of the integer datapath
    localparam int xlen = 32;

    // register index width and the register count that follows from it
    localparam int reg_id_bits = 5;
    localparam int reg_count = 1 << reg_id_bits;

    // x0 reads as zero, so it is never renamed and never written
    localparam logic [reg_id_bits-1:0] zero_reg = '0;

endpackage
